// ==== Bender.yml ====
package:
  name: trellis_front_end

sources:
  - include_dirs:
      - design
    files:
      - design/trellisPkg.sv
      - design/iqSatDoubler.sv
      - design/phaseErrorScaler.sv
      - design/midSymbolTimer.sv
      - design/dacMonitorMux.sv
      - design/trellisFrontEnd.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - testbench/trellisChecker.sv
      - testbench/tbTrellisFrontEnd.sv

// ==== design/dacMonitorMux.sv ====
// DAC monitor mux
`timescale 1ns/1ps
`default_nettype none

`include "trellis_cfg.svh"

module dacMonitorMux (
  input  logic                                        clk,
  input  logic                                        rstN,
  input  trellisPkg::dacSel_t    [`DAC_CHANNELS-1:0]  dacSelect,
  input  trellisPkg::iqSample_t                       sampleIn,
  input  trellisPkg::symStrobe_t                      strobeIn,
  input  trellisPkg::symStrobe_t                      strobeX2,
  input  trellisPkg::phErr_t                          phaseError,
  output trellisPkg::dacChannel_t [`DAC_CHANNELS-1:0] dacOut
);
  import trellisPkg::*;

  // phase error left justified on the DAC
  logic [`SAMPLE_W-1:0] phErrWord;

  assign phErrWord = {phaseError, {`DAC_PAD{1'b0}}};

  // ----------------------------------------------------------------------
  // one registered selector per channel
  // ----------------------------------------------------------------------
  for (genvar ch = 0; ch < `DAC_CHANNELS; ch++) begin : gChan
    dacChannel_t chReg;

    always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
        chReg <= '0;
      end else begin
        case (dacSelect[ch])
          // raw loop outputs, synced on every sample
          dacSelI: begin
            chReg.data <= sampleIn.i;
            chReg.sync <= strobeIn.sym2xEn;
          end
          dacSelQ: begin
            chReg.data <= sampleIn.q;
            chReg.sync <= strobeIn.sym2xEn;
          end
          // dacSelPhErr and spare codes, synced once a symbol
          default: begin
            chReg.data <= phErrWord;
            chReg.sync <= strobeX2.symEn;
          end
        endcase
      end
    end

    assign dacOut[ch] = chReg;
  end

endmodule

`default_nettype wire

// ==== design/iqSatDoubler.sv ====
// Saturating IQ doubler
`timescale 1ns/1ps
`default_nettype none

`include "trellis_cfg.svh"

module iqSatDoubler (
  input  logic                   clk,
  input  logic                   rstN,
  input  trellisPkg::symStrobe_t strobeIn,
  input  trellisPkg::iqSample_t  sampleIn,
  output trellisPkg::symStrobe_t strobeX2,
  output trellisPkg::iqSample_t  sampleX2
);
  import trellisPkg::*;

  // symmetric clip limits, the most negative code stays out
  localparam sample_t sampleMax = {1'b0, {(`SAMPLE_W-1){1'b1}}};
  localparam sample_t sampleMin = -sampleMax;

  // strobe-qualified sample, first stage
  iqSample_t  capSample;
  // strobe pipe matching the sample path
  symStrobe_t strobeSr [`DBL_LAT];

  // twice the input, clipped to +/- full scale
  function automatic sample_t satDouble(input sample_t d);
    logic signed [`SAMPLE_W:0] dbl;
    dbl = {d, 1'b0};
    if (dbl > sampleMax) begin
      satDouble = sampleMax;
    end else if (dbl < sampleMin) begin
      satDouble = sampleMin;
    end else begin
      satDouble = dbl[`SAMPLE_W-1:0];
    end
  endfunction

  // ----------------------------------------------------------------------
  // sample path
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      capSample <= '0;
      sampleX2  <= '0;
    end else begin
      // capture on either strobe
      if (strobeIn.symEn | strobeIn.sym2xEn) begin
        capSample <= sampleIn;
      end
      // held capture just keeps re-doubling to the same value
      sampleX2.i <= satDouble(capSample.i);
      sampleX2.q <= satDouble(capSample.q);
    end
  end

  // ----------------------------------------------------------------------
  // strobe alignment
  // ----------------------------------------------------------------------
  // two deep so back to back strobes both get through
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int k = 0; k < `DBL_LAT; k++) begin
        strobeSr[k] <= '0;
      end
    end else begin
      strobeSr[0] <= strobeIn;
      for (int k = 1; k < `DBL_LAT; k++) begin
        strobeSr[k] <= strobeSr[k-1];
      end
    end
  end

  assign strobeX2 = strobeSr[`DBL_LAT-1];

  // clipping is symmetric, so -2^17 never reaches the filters
  noMinCode: assert property (@(posedge clk) disable iff (!rstN)
    sampleX2.i != {1'b1, {(`SAMPLE_W-1){1'b0}}})
    else $error("sampleX2.i hit the most negative code");

endmodule

`default_nettype wire

// ==== design/midSymbolTimer.sv ====
// Mid-symbol strobe taps
`timescale 1ns/1ps
`default_nettype none

`include "trellis_cfg.svh"

module midSymbolTimer (
  input  logic                   clk,
  input  logic                   rstN,
  input  trellisPkg::symStrobe_t strobeX2,
  output logic                   rotEna,
  output logic                   trellEna
);

  // second sample of the symbol
  logic                midSym;
  // bit n carries midSym from n+1 cycles back
  logic [`TRELL_TAP:0] midSr;

  assign midSym = strobeX2.sym2xEn & ~strobeX2.symEn;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      midSr <= '0;
    end else begin
      midSr <= {midSr[`TRELL_TAP-1:0], midSym};
    end
  end

  // rotator fires first, decoder once rotator outputs settle
  assign rotEna   = midSr[`ROT_TAP];
  assign trellEna = midSr[`TRELL_TAP];

  // decoder enable lags the rotator by a fixed gap
  rotToTrell: assert property (@(posedge clk) disable iff (!rstN)
    rotEna |-> ##(`TRELL_TAP - `ROT_TAP) trellEna)
    else $error("trellEna missing after rotEna");

endmodule

`default_nettype wire

// ==== design/phaseErrorScaler.sv ====
// Phase error feedback scaler
`timescale 1ns/1ps
`default_nettype none

`include "trellis_cfg.svh"

module phaseErrorScaler (
  input  logic               clk,
  input  logic               rstN,
  input  trellisPkg::phErr_t phaseError,
  output trellisPkg::phFb_t  phaseErrorFb
);
  import trellisPkg::*;

  // low phase error bits that survive the shift
  localparam int keepW = `PHFB_W - `PHFB_SHIFT;
  // clip levels, symmetric about zero
  localparam phFb_t fbMax = {1'b0, {(`PHFB_W-1){1'b1}}};
  localparam phFb_t fbMin = -fbMax;

  // sign bit plus everything above the kept bits
  logic [`PHERR_W-keepW:0] topBits;
  // first stage
  phFb_t shifted;
  logic  ovPos;
  logic  ovNeg;

  assign topBits = phaseError[`PHERR_W-1:keepW-1];

  // ----------------------------------------------------------------------
  // stage 1, shift and overflow detect
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      shifted <= '0;
      ovPos   <= 1'b0;
      ovNeg   <= 1'b0;
    end else begin
      shifted <= {phaseError[keepW-1:0], {`PHFB_SHIFT{1'b0}}};
      // not a clean sign extension means the shift would wrap
      ovPos   <= ~phaseError[`PHERR_W-1] & (|topBits);
      ovNeg   <= phaseError[`PHERR_W-1] & ~(&topBits);
    end
  end

  // ----------------------------------------------------------------------
  // stage 2, pick clipped or shifted word
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      phaseErrorFb <= '0;
    end else if (ovPos) begin
      phaseErrorFb <= fbMax;
    end else if (ovNeg) begin
      phaseErrorFb <= fbMin;
    end else begin
      phaseErrorFb <= shifted;
    end
  end

  // flags come from opposite signs
  ovExclusive: assert property (@(posedge clk) disable iff (!rstN)
    !(ovPos && ovNeg))
    else $error("phase error overflow flagged both ways");

endmodule

`default_nettype wire

// ==== design/trellisFrontEnd.sv ====
// Trellis demodulator front end
`timescale 1ns/1ps
`default_nettype none

`include "trellis_cfg.svh"

module trellisFrontEnd (
  input  logic                                        clk,
  input  logic                                        rstN,
  input  trellisPkg::iqSample_t                       sampleIn,
  input  trellisPkg::symStrobe_t                      strobeIn,
  input  trellisPkg::phErr_t                          phaseError,
  input  trellisPkg::dacSel_t    [`DAC_CHANNELS-1:0]  dacSelect,
  output trellisPkg::iqSample_t                       sampleX2,
  output trellisPkg::symStrobe_t                      strobeX2,
  output logic                                        rotEna,
  output logic                                        trellEna,
  output trellisPkg::phFb_t                           phaseErrorFb,
  output trellisPkg::dacChannel_t [`DAC_CHANNELS-1:0] dacOut
);

  // ----------------------------------------------------------------------
  // sample side
  // ----------------------------------------------------------------------
  // undo the half scale of the loop's complex multiply
  iqSatDoubler u_doubler (
    .clk      (clk),
    .rstN     (rstN),
    .strobeIn (strobeIn),
    .sampleIn (sampleIn),
    .strobeX2 (strobeX2),
    .sampleX2 (sampleX2)
  );

  // rotator and decoder enables off the aligned strobes
  midSymbolTimer u_timer (
    .clk      (clk),
    .rstN     (rstN),
    .strobeX2 (strobeX2),
    .rotEna   (rotEna),
    .trellEna (trellEna)
  );

  // ----------------------------------------------------------------------
  // decoder side
  // ----------------------------------------------------------------------
  // feedback into the carrier loop
  phaseErrorScaler u_scaler (
    .clk          (clk),
    .rstN         (rstN),
    .phaseError   (phaseError),
    .phaseErrorFb (phaseErrorFb)
  );

  // lab monitor outputs
  dacMonitorMux u_dacMux (
    .clk        (clk),
    .rstN       (rstN),
    .dacSelect  (dacSelect),
    .sampleIn   (sampleIn),
    .strobeIn   (strobeIn),
    .strobeX2   (strobeX2),
    .phaseError (phaseError),
    .dacOut     (dacOut)
  );

endmodule

`default_nettype wire

// ==== design/trellisPkg.sv ====
// Trellis front end types
`default_nettype none

`include "trellis_cfg.svh"

package trellisPkg;

  // ----------------------------------------------------------------------
  // samples
  // ----------------------------------------------------------------------
  // one signed I or Q value
  typedef logic signed [`SAMPLE_W-1:0] sample_t;

  // complex sample, i in the upper half
  typedef struct packed {
    sample_t i;
    sample_t q;
  } iqSample_t;

  // one-cycle qualifiers, symEn marks the first sample of a symbol
  typedef struct packed {
    logic symEn;
    logic sym2xEn;
  } symStrobe_t;

  // ----------------------------------------------------------------------
  // phase error path
  // ----------------------------------------------------------------------
  // raw decoder phase error
  typedef logic signed [`PHERR_W-1:0] phErr_t;
  // scaled feedback into the carrier loop
  typedef logic signed [`PHFB_W-1:0] phFb_t;

  // ----------------------------------------------------------------------
  // DAC monitor
  // ----------------------------------------------------------------------
  // per-channel source select, unused codes fall back to phase error
  typedef enum logic [1:0] {
    dacSelI     = 2'd0,
    dacSelQ     = 2'd1,
    dacSelPhErr = 2'd2
  } dacSel_t;

  // one DAC word plus its sync pulse
  typedef struct packed {
    logic                 sync;
    logic [`SAMPLE_W-1:0] data;
  } dacChannel_t;

endpackage

`default_nettype wire

// ==== design/trellis_cfg.svh ====
// Trellis front end configuration
`ifndef TRELLIS_CFG_SVH
`define TRELLIS_CFG_SVH

// ----------------------------------------------------------------------
// number formats
// ----------------------------------------------------------------------
// I and Q sample width from the carrier loop
`define SAMPLE_W 18
// decoder phase error width
`define PHERR_W 10
// loop feedback word width
`define PHFB_W 8
// kept phase error bits move up by this much
`define PHFB_SHIFT 3

// ----------------------------------------------------------------------
// timing
// ----------------------------------------------------------------------
// doubler pipeline depth
`define DBL_LAT 2
// taps in the mid-symbol delay line
`define ROT_TAP 4
`define TRELL_TAP 11

// ----------------------------------------------------------------------
// DAC monitor
// ----------------------------------------------------------------------
`define DAC_CHANNELS 3
// zero bits below the phase error on a DAC word
`define DAC_PAD 8

`endif

// ==== flist.f ====
+incdir+design
design/trellisPkg.sv
design/iqSatDoubler.sv
design/phaseErrorScaler.sv
design/midSymbolTimer.sv
design/dacMonitorMux.sv
design/trellisFrontEnd.sv
testbench/trellisChecker.sv
testbench/tbTrellisFrontEnd.sv

// ==== testbench/tbTrellisFrontEnd.sv ====
// Trellis front end testbench
`timescale 1ns/1ps
`default_nettype none

`include "trellis_cfg.svh"

module tbTrellisFrontEnd;
  import trellisPkg::*;

  localparam int  testCycles = 3000;
  localparam real clkPeriod  = 4.0;

  logic                            clk;
  logic                            rstN;
  iqSample_t                       sampleIn;
  symStrobe_t                      strobeIn;
  phErr_t                          phaseError;
  dacSel_t     [`DAC_CHANNELS-1:0] dacSelect;
  iqSample_t                       sampleX2;
  symStrobe_t                      strobeX2;
  logic                            rotEna;
  logic                            trellEna;
  phFb_t                           phaseErrorFb;
  dacChannel_t [`DAC_CHANNELS-1:0] dacOut;
  int                              checkCount;
  int                              errCount;

  logic [31:0] lfsr = 32'h1c49_21d5;
  // symbol timing state
  int          symPeriod;
  int          symPhase;

  trellisFrontEnd u_dut (
    .clk          (clk),
    .rstN         (rstN),
    .sampleIn     (sampleIn),
    .strobeIn     (strobeIn),
    .phaseError   (phaseError),
    .dacSelect    (dacSelect),
    .sampleX2     (sampleX2),
    .strobeX2     (strobeX2),
    .rotEna       (rotEna),
    .trellEna     (trellEna),
    .phaseErrorFb (phaseErrorFb),
    .dacOut       (dacOut)
  );

  trellisChecker u_checker (
    .clk          (clk),
    .rstN         (rstN),
    .sampleIn     (sampleIn),
    .strobeIn     (strobeIn),
    .phaseError   (phaseError),
    .dacSelect    (dacSelect),
    .sampleX2     (sampleX2),
    .strobeX2     (strobeX2),
    .rotEna       (rotEna),
    .trellEna     (trellEna),
    .phaseErrorFb (phaseErrorFb),
    .dacOut       (dacOut),
    .checkCount   (checkCount),
    .errCount     (errCount)
  );

  // ----------------------------------------------------------------------
  // random source
  // ----------------------------------------------------------------------
  // Galois form, taps 32 31 29 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'hD000_0001;
    return s >> 1;
  endfunction

  // one step per bit taken, msb first
  task automatic takeBits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsrStep(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // full range half the time, otherwise small and unclipped
  task automatic drawSample(output sample_t s);
    logic [31:0] mode;
    logic [31:0] v;
    takeBits(1, mode);
    if (mode[0]) begin
      takeBits(`SAMPLE_W, v);
      s = v[`SAMPLE_W-1:0];
    end else begin
      takeBits(12, v);
      s = {{(`SAMPLE_W-12){v[11]}}, v[11:0]};
    end
  endtask

  // narrow draws sit around the feedback clip point
  task automatic drawPhErr(output phErr_t p);
    logic [31:0] mode;
    logic [31:0] v;
    takeBits(1, mode);
    if (mode[0]) begin
      takeBits(`PHERR_W, v);
      p = v[`PHERR_W-1:0];
    end else begin
      takeBits(6, v);
      p = {{(`PHERR_W-6){v[5]}}, v[5:0]};
    end
  endtask

  task automatic driveCycle(input int cyc);
    logic [31:0] v;
    sample_t     si;
    sample_t     sq;
    phErr_t      pe;
    // symEn on the first sample, lone sym2xEn half a period on
    strobeIn.symEn   = (symPhase == 0);
    strobeIn.sym2xEn = (symPhase == 0) || (symPhase == symPeriod / 2);
    symPhase++;
    if (symPhase == symPeriod) begin
      symPhase = 0;
      takeBits(2, v);
      symPeriod = 4 + v[1:0];
    end
    drawSample(si);
    drawSample(sq);
    drawPhErr(pe);
    sampleIn.i = si;
    sampleIn.q = sq;
    phaseError = pe;
    // spare code 3 included
    if (cyc % 64 == 0) begin
      for (int ch = 0; ch < `DAC_CHANNELS; ch++) begin
        takeBits(2, v);
        dacSelect[ch] = dacSel_t'(v[1:0]);
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // clock, stimulus, watchdog
  // ----------------------------------------------------------------------
  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  initial begin
    rstN       = 1'b0;
    sampleIn   = '0;
    strobeIn   = '0;
    phaseError = '0;
    for (int ch = 0; ch < `DAC_CHANNELS; ch++) begin
      dacSelect[ch] = dacSelI;
    end
    symPeriod = 4;
    symPhase  = 0;
    repeat (10) @(negedge clk);
    rstN = 1'b1;
    for (int cyc = 0; cyc < testCycles; cyc++) begin
      @(negedge clk);
      driveCycle(cyc);
    end
    // drain the trellis delay line
    @(negedge clk);
    strobeIn = '0;
    repeat (16) @(negedge clk);
    $display("checks: %0d  errors: %0d", checkCount, errCount);
    if (errCount == 0 && checkCount > 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #(testCycles * clkPeriod * 1.5);
    $display("timeout: the run did not reach its end in the allowed time");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/trellisChecker.sv ====
// Front end reference model
`timescale 1ns/1ps
`default_nettype none

`include "trellis_cfg.svh"

module trellisChecker (
  input  logic                                        clk,
  input  logic                                        rstN,
  input  trellisPkg::iqSample_t                       sampleIn,
  input  trellisPkg::symStrobe_t                      strobeIn,
  input  trellisPkg::phErr_t                          phaseError,
  input  trellisPkg::dacSel_t    [`DAC_CHANNELS-1:0]  dacSelect,
  input  trellisPkg::iqSample_t                       sampleX2,
  input  trellisPkg::symStrobe_t                      strobeX2,
  input  logic                                        rotEna,
  input  logic                                        trellEna,
  input  trellisPkg::phFb_t                           phaseErrorFb,
  input  trellisPkg::dacChannel_t [`DAC_CHANNELS-1:0] dacOut,
  output int                                          checkCount,
  output int                                          errCount
);
  import trellisPkg::*;

  // deep enough for the trellis tap, 14 back
  localparam int histLen = 16;
  localparam int rotLag = `DBL_LAT + `ROT_TAP + 1;
  localparam int trellLag = `DBL_LAT + `TRELL_TAP + 1;

  // index 0 holds this cycle's inputs
  iqSample_t                  sampleHist [histLen];
  symStrobe_t                 strobeHist [histLen];
  phErr_t                     phErrHist  [histLen];
  logic [2*`DAC_CHANNELS-1:0] selHist    [histLen];

  logic [1:0]           sel;
  logic [`SAMPLE_W-1:0] expData;
  logic                 expSync;
  // previous edge was already in reset
  logic                 rstHeld;

  initial begin
    checkCount = 0;
    errCount   = 0;
    rstHeld    = 1'b0;
  end

  // ----------------------------------------------------------------------
  // reference rules
  // ----------------------------------------------------------------------
  // times two, clipped to +/- full scale
  function automatic int dblRef(input int x);
    int lim;
    lim = (1 << (`SAMPLE_W-1)) - 1;
    if (2 * x > lim) return lim;
    if (2 * x < -lim) return -lim;
    return 2 * x;
  endfunction

  // times eight while it fits, else +/-127
  function automatic int fbRef(input int p);
    int span;
    span = 1 << (`PHFB_W - `PHFB_SHIFT - 1);
    if (p >= -span && p < span) return p * (1 << `PHFB_SHIFT);
    if (p > 0) return (1 << (`PHFB_W-1)) - 1;
    return -((1 << (`PHFB_W-1)) - 1);
  endfunction

  // second sample of a symbol
  function automatic logic midOf(input symStrobe_t s);
    return s.sym2xEn & ~s.symEn;
  endfunction

  // unknown bits count as a mismatch
  task automatic checkValue(input string name,
                            input logic signed [63:0] got,
                            input logic signed [63:0] exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("** Error @ %0t: %s = %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  // ----------------------------------------------------------------------
  // compare on the rising edge, DUT outputs still hold last cycle's state
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    if (!rstN) begin
      // reset state is settled once an earlier edge saw reset
      if (rstHeld) begin
        checkValue("strobeX2", strobeX2, 0);
        checkValue("rotEna", rotEna, 0);
        checkValue("trellEna", trellEna, 0);
        for (int ch = 0; ch < `DAC_CHANNELS; ch++) begin
          checkValue($sformatf("dacOut[%0d].sync", ch), dacOut[ch].sync, 0);
        end
      end
      rstHeld = 1'b1;
      // idle history matches the reset state
      for (int k = 0; k < histLen; k++) begin
        sampleHist[k] = '0;
        strobeHist[k] = '0;
        phErrHist[k]  = '0;
        selHist[k]    = '0;
      end
    end else begin
      rstHeld = 1'b0;
      for (int k = histLen - 1; k > 0; k--) begin
        sampleHist[k] = sampleHist[k-1];
        strobeHist[k] = strobeHist[k-1];
        phErrHist[k]  = phErrHist[k-1];
        selHist[k]    = selHist[k-1];
      end
      sampleHist[0] = sampleIn;
      strobeHist[0] = strobeIn;
      phErrHist[0]  = phaseError;
      selHist[0]    = dacSelect;

      // doubler, strobe and sample both 2 back
      checkValue("strobeX2", strobeX2, strobeHist[`DBL_LAT]);
      if (strobeHist[`DBL_LAT] != '0) begin
        checkValue("sampleX2.i", sampleX2.i, dblRef(sampleHist[`DBL_LAT].i));
        checkValue("sampleX2.q", sampleX2.q, dblRef(sampleHist[`DBL_LAT].q));
      end

      // enables off the mid-symbol strobe
      checkValue("rotEna", rotEna, midOf(strobeHist[rotLag]));
      checkValue("trellEna", trellEna, midOf(strobeHist[trellLag]));

      checkValue("phaseErrorFb", phaseErrorFb, fbRef(phErrHist[2]));

      // DAC, one cycle behind its inputs, strobeX2 is itself 2 behind
      for (int ch = 0; ch < `DAC_CHANNELS; ch++) begin
        sel = selHist[1][2*ch +: 2];
        if (sel == dacSelI) begin
          expData = sampleHist[1].i;
          expSync = strobeHist[1].sym2xEn;
        end else if (sel == dacSelQ) begin
          expData = sampleHist[1].q;
          expSync = strobeHist[1].sym2xEn;
        end else begin
          expData = {phErrHist[1], {`DAC_PAD{1'b0}}};
          expSync = strobeHist[`DBL_LAT + 1].symEn;
        end
        checkValue($sformatf("dacOut[%0d].data", ch), dacOut[ch].data, expData);
        checkValue($sformatf("dacOut[%0d].sync", ch), dacOut[ch].sync, expSync);
      end
    end
  end

endmodule

`default_nettype wire
